/* bios_word_packer.sv */
/*
 * BIOS word packer: pairs host halfwords into 32-bit BIOS words
 */
`timescale 1ns/100ps

module bios_word_packer import gba_loader_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   is_bios_i,
	input  logic                   wr_i,
	input  logic [ADDR_W-1:0]      addr_i,
	input  logic [DATA_W-1:0]      dout_i,
	output logic [BIOS_ADDR_W-1:0] bios_wraddr_o,
	output logic [31:0]            bios_wrdata_o,
	output logic                   bios_wr_o
);

	logic bios_we;

	assign bios_we = is_bios_i && wr_i;

	// Strobe only on the upper halfword
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr_o <= 1'b0;
		else
			bios_wr_o <= bios_we && addr_i[1];
	end

	always_ff @(posedge clk_sys) begin
		if (bios_we) begin
			if (!addr_i[1]) begin
				bios_wrdata_o[15:0] <= dout_i;  // Low half waits for its partner
			end else begin
				bios_wrdata_o[31:16] <= dout_i;
				bios_wraddr_o        <= addr_i[13:2];
			end
		end
	end

	// Halfword pairs alternate, so a word never follows a word directly
	a_bios_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr_o |=> !bios_wr_o);

endmodule

/* cart_header_scanner.sv */
/*
 * Cartridge scanner: loaded flag, cart type, top pak address and
 * detection of the FLASH1M_V marker anywhere in the image
 */
`timescale 1ns/100ps

module cart_header_scanner import gba_loader_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  is_cart_i,
	input  logic                  cart_start_i,
	input  logic                  cart_end_i,
	input  logic [1:0]            cart_type_i,
	input  logic                  wr_i,
	input  logic [ADDR_W-1:0]     addr_i,
	input  logic [DATA_W-1:0]     dout_i,
	output logic                  cart_loaded_o,
	output logic [1:0]            cart_type_o,
	output logic [PAK_ADDR_W-1:0] max_pak_addr_o,
	output logic                  flash_1m_o
);

	// Byte history, newest byte lowest
	logic [(FLASH_MARK_LEN-1)*8-1:0] hist_q;
	logic [(FLASH_MARK_LEN-1)*8-1:0] hist_base;
	logic                            cart_we;
	logic                            mark_lo;   // Marker ends on the low byte
	logic                            mark_hi;   // Marker ends on the high byte

	assign cart_we   = is_cart_i && wr_i;
	assign hist_base = cart_start_i ? '0 : hist_q;   // Fresh image starts empty

	assign mark_lo = ({hist_base, dout_i[7:0]} == FLASH_MARK);
	assign mark_hi = ({hist_base[(FLASH_MARK_LEN-2)*8-1:0], dout_i[7:0], dout_i[15:8]}
		== FLASH_MARK);

	// ========================================
	// Cart facts
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_loaded_o  <= 1'b0;
			cart_type_o    <= 2'd0;
			max_pak_addr_o <= '0;
			flash_1m_o     <= 1'b0;
		end else begin
			if (cart_start_i) begin
				cart_loaded_o <= 1'b1;
				cart_type_o   <= cart_type_i;
				flash_1m_o    <= 1'b0;
			end
			if (cart_we && (mark_lo || mark_hi))
				flash_1m_o <= 1'b1;   // Wins over the clear at start
			if (cart_end_i)
				max_pak_addr_o <= addr_i[ADDR_W-1:2];   // Last written byte address
		end
	end

	// ========================================
	// Marker history
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (cart_we)
			hist_q <= {hist_base[(FLASH_MARK_LEN-3)*8-1:0], dout_i[7:0], dout_i[15:8]};
		else if (cart_start_i)
			hist_q <= '0;
	end

endmodule

/* cart_quirk_matcher.sv */
/*
 * Quirk matcher: captures the 12-byte game title from the cart header
 * and looks it up in the SRAM and memory-remap quirk table
 */
`timescale 1ns/100ps

module cart_quirk_matcher import gba_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              is_cart_i,
	input  logic              cart_start_i,
	input  logic              wr_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] dout_i,
	output logic              sram_quirk_o,
	output logic              memory_remap_quirk_o
);

	logic [TITLE_LEN*8-1:0] title_q;   // First character in the top byte
	logic                   cart_we;
	logic                   in_title;
	logic [3:0]             title_off;
	logic [6:0]             title_lsb;
	logic                   hit_any;
	logic                   hit_remap;

	assign cart_we   = is_cart_i && wr_i;
	assign in_title  = (addr_i >= TITLE_BASE) && (addr_i < TITLE_DONE_ADDR);
	assign title_off = addr_i[3:0] - TITLE_BASE[3:0];
	assign title_lsb = {4'(TITLE_LEN - 2) - title_off, 3'd0};   // Halfword bit position

	// Header bytes arrive low byte first, swap into string order
	always_ff @(posedge clk_sys) begin
		if (cart_we && in_title)
			title_q[title_lsb +: 16] <= {dout_i[7:0], dout_i[15:8]};
	end

	// Table lookup
	always_comb begin
		hit_any   = 1'b0;
		hit_remap = 1'b0;
		for (int i = 0; i < QUIRK_N; i++) begin
			if (title_q == QUIRK_TITLES[i]) begin
				hit_any   = 1'b1;
				hit_remap = hit_remap | QUIRK_REMAP[i];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || cart_start_i) begin
			sram_quirk_o         <= 1'b0;
			memory_remap_quirk_o <= 1'b0;
		end else if (cart_we && (addr_i == TITLE_DONE_ADDR)) begin
			if (hit_any)   sram_quirk_o         <= 1'b1;
			if (hit_remap) memory_remap_quirk_o <= 1'b1;
		end
	end

endmodule

/* cheat_code_assembler.sv */
/*
 * Cheat code assembler: builds 128-bit cheat records from the code file
 * and flags each complete record and the start of a new code list
 */
`timescale 1ns/100ps

module cheat_code_assembler import gba_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              is_code_i,
	input  logic              code_start_i,
	input  logic              wr_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] dout_i,
	output cheat_code_u       cheat_code_o,
	output logic              cheat_valid_o,
	output logic              cheat_clear_o
);

	logic       code_we;
	logic [2:0] slot;

	assign code_we = is_code_i && wr_i && !addr_i[0];   // Halfword aligned only

	// Byte offset to slot
	// Field 0 (flags) is at offsets 0..3 but lives in slots 7:6, low half first
	assign slot = {~addr_i[3], ~addr_i[2], addr_i[1]};

	always_ff @(posedge clk_sys) begin
		if (code_we)
			cheat_code_o.half[slot] <= dout_i;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid_o <= 1'b0;
			cheat_clear_o <= 1'b0;
		end else begin
			cheat_valid_o <= code_we && (addr_i[3:0] == 4'd14);   // Replace top ends a record
			cheat_clear_o <= code_start_i;                       // New list drops old codes
		end
	end

	// A list clear in the same cycle would drop the finished record
	a_valid_no_clear: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid_o |-> !cheat_clear_o);

endmodule

/* dl_classifier.sv */
/*
 * Download classifier: registers the host stream and sorts it into
 * BIOS, cheat code or cartridge, with start and end strobes
 */
`timescale 1ns/100ps

module dl_classifier import gba_loader_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              ioctl_download_i,
	input  logic [7:0]        ioctl_index_i,
	input  logic [ADDR_W-1:0] ioctl_addr_i,
	input  logic [DATA_W-1:0] ioctl_dout_i,
	input  logic              ioctl_wr_i,
	output logic              wr_o,
	output logic [ADDR_W-1:0] addr_o,
	output logic [DATA_W-1:0] dout_o,
	output logic              is_bios_o,
	output logic              is_cart_o,
	output logic              is_code_o,
	output logic [1:0]        cart_type_o,
	output logic              cart_start_o,
	output logic              cart_end_o,
	output logic              code_start_o
);

	logic kind_bios, kind_code, kind_cart;
	logic dl_prev;   // Download level one cycle back
	logic dl_rise;

	assign kind_bios = (ioctl_index_i == IDX_BIOS);
	assign kind_code = (ioctl_index_i == IDX_CODE);
	assign kind_cart = !kind_bios && !kind_code;   // Every other index is a cart
	assign dl_rise   = ioctl_download_i && !dl_prev;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_o         <= 1'b0;
			is_bios_o    <= 1'b0;
			is_cart_o    <= 1'b0;
			is_code_o    <= 1'b0;
			cart_start_o <= 1'b0;
			cart_end_o   <= 1'b0;
			code_start_o <= 1'b0;
			dl_prev      <= 1'b0;
		end else begin
			wr_o         <= ioctl_wr_i;
			is_bios_o    <= ioctl_download_i && kind_bios;
			is_cart_o    <= ioctl_download_i && kind_cart;
			is_code_o    <= ioctl_download_i && kind_code;
			cart_start_o <= dl_rise && kind_cart;
			code_start_o <= dl_rise && kind_code;
			cart_end_o   <= is_cart_o && !ioctl_download_i; // Falling edge of a cart load
			dl_prev      <= ioctl_download_i;
		end
	end

	// Address and data hold the last written values, so the end strobe sees the top address
	always_ff @(posedge clk_sys) begin
		cart_type_o <= ioctl_index_i[7:6];
		if (ioctl_wr_i) begin
			addr_o <= ioctl_addr_i;
			dout_o <= ioctl_dout_i;
		end
	end

	a_kind_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({is_bios_o, is_cart_o, is_code_o}));

endmodule

/* gba_loader_pkg.sv */
/*
 * Shared constants and types for the GBA download front end
 * Host stream widths, download indices, flash marker, quirk table, cheat record
 */
package gba_loader_pkg;

	// ========================================
	// Host stream
	// ========================================
	localparam logic [7:0] IDX_BIOS = 8'd0;   // Index of the BIOS image
	localparam logic [7:0] IDX_CODE = 8'd255; // Index of the cheat file
	localparam int ADDR_W      = 27;          // Host byte address
	localparam int DATA_W      = 16;          // Host halfword
	localparam int BIOS_ADDR_W = 12;          // Word address, byte addr 13:2
	localparam int PAK_ADDR_W  = 25;          // Last byte addr 26:2

	// ========================================
	// Cartridge header
	// ========================================
	localparam int FLASH_MARK_LEN = 9;
	localparam logic [FLASH_MARK_LEN*8-1:0] FLASH_MARK = "FLASH1M_V";

	localparam int TITLE_LEN = 12;                                // Title bytes in header
	localparam logic [ADDR_W-1:0] TITLE_BASE      = 27'h00000A0; // First title byte
	localparam logic [ADDR_W-1:0] TITLE_DONE_ADDR = 27'h00000AC; // Write here starts compare

	// Titles that need the SRAM quirk, zero padded to full length
	localparam int QUIRK_N = 8;
	localparam logic [TITLE_LEN*8-1:0] QUIRK_TITLES [QUIRK_N] = '{
		{"ROCKY BOXING"},            // 0
		{"DBZ LGCYGOKU"},            // 1
		{"IRIDIONII", 24'h000000},   // 2
		{"TOPGUN CZ", 24'h000000},   // 3
		{"BOMBER MAN", 16'h0000},    // 4  NES classic
		{"CASTLEVANIA", 8'h00},      // 5  NES classic
		{"SUPER MARIO", 8'h00},      // 6  NES classic
		{"ZELDA 1", 40'h0000000000}  // 7  NES classic
	};

	// Bit i set when entry i also remaps memory (NES classics)
	localparam logic [QUIRK_N-1:0] QUIRK_REMAP = 8'b1111_0000;

	// ========================================
	// Cheat record
	// ========================================
	// Filled as halfwords by the loader, consumed as four words by the core
	typedef union packed {
		logic [7:0][DATA_W-1:0] half;  // Slot 7 is the top halfword of flags
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} field;
	} cheat_code_u;

endpackage

/* gba_loader_top.f */
gba_loader_pkg.sv
dl_classifier.sv
bios_word_packer.sv
cheat_code_assembler.sv
cart_header_scanner.sv
cart_quirk_matcher.sv
gba_loader_top.sv
tb_gba_loader.sv

/* gba_loader_top.sv */
/*
 * GBA download front end: classifier feeding BIOS, cheat, cart and quirk stages
 */
`timescale 1ns/100ps

module gba_loader_top import gba_loader_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ioctl_download_i,
	input  logic [7:0]             ioctl_index_i,
	input  logic [ADDR_W-1:0]      ioctl_addr_i,
	input  logic [DATA_W-1:0]      ioctl_dout_i,
	input  logic                   ioctl_wr_i,
	output logic [BIOS_ADDR_W-1:0] bios_wraddr_o,
	output logic [31:0]            bios_wrdata_o,
	output logic                   bios_wr_o,
	output cheat_code_u            cheat_code_o,
	output logic                   cheat_valid_o,
	output logic                   cheat_clear_o,
	output logic                   cart_loaded_o,
	output logic [1:0]             cart_type_o,
	output logic [PAK_ADDR_W-1:0]  max_pak_addr_o,
	output logic                   flash_1m_o,
	output logic                   sram_quirk_o,
	output logic                   memory_remap_quirk_o
);

	// Registered stream shared by all consumers
	logic              dl_wr;
	logic [ADDR_W-1:0] dl_addr;
	logic [DATA_W-1:0] dl_dout;
	logic              is_bios, is_cart, is_code;
	logic [1:0]        dl_cart_type;
	logic              cart_start, cart_end, code_start;

	dl_classifier u_classifier (
		.clk_sys, .reset,
		.ioctl_download_i, .ioctl_index_i, .ioctl_addr_i, .ioctl_dout_i, .ioctl_wr_i,
		.wr_o(dl_wr), .addr_o(dl_addr), .dout_o(dl_dout),
		.is_bios_o(is_bios), .is_cart_o(is_cart), .is_code_o(is_code),
		.cart_type_o(dl_cart_type), .cart_start_o(cart_start),
		.cart_end_o(cart_end), .code_start_o(code_start)
	);

	bios_word_packer u_bios (
		.clk_sys, .reset, .is_bios_i(is_bios),
		.wr_i(dl_wr), .addr_i(dl_addr), .dout_i(dl_dout),
		.bios_wraddr_o, .bios_wrdata_o, .bios_wr_o
	);

	cheat_code_assembler u_cheat (
		.clk_sys, .reset, .is_code_i(is_code), .code_start_i(code_start),
		.wr_i(dl_wr), .addr_i(dl_addr), .dout_i(dl_dout),
		.cheat_code_o, .cheat_valid_o, .cheat_clear_o
	);

	cart_header_scanner u_scanner (
		.clk_sys, .reset, .is_cart_i(is_cart),
		.cart_start_i(cart_start), .cart_end_i(cart_end), .cart_type_i(dl_cart_type),
		.wr_i(dl_wr), .addr_i(dl_addr), .dout_i(dl_dout),
		.cart_loaded_o, .cart_type_o, .max_pak_addr_o, .flash_1m_o
	);

	cart_quirk_matcher u_quirk (
		.clk_sys, .reset, .is_cart_i(is_cart), .cart_start_i(cart_start),
		.wr_i(dl_wr), .addr_i(dl_addr), .dout_i(dl_dout),
		.sram_quirk_o, .memory_remap_quirk_o
	);

endmodule

/* run_sim.sh */
#!/bin/bash
# Build the GBA loader testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_gba_loader -f gba_loader_top.f \
	&& ./obj_dir/Vtb_gba_loader > sim.log 2>&1 \
	|| { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

/* tb_gba_loader.sv */
/*
 * Testbench for the GBA download front end
 * Random BIOS, cheat and cart downloads checked against a reference model
 */
`timescale 1ns/100ps

module tb_gba_loader import gba_loader_pkg::*; ();

	logic                   clk_sys, reset;
	logic                   ioctl_download_i, ioctl_wr_i;
	logic [7:0]             ioctl_index_i;
	logic [ADDR_W-1:0]      ioctl_addr_i;
	logic [DATA_W-1:0]      ioctl_dout_i;
	logic [BIOS_ADDR_W-1:0] bios_wraddr_o;
	logic [31:0]            bios_wrdata_o;
	logic                   bios_wr_o, cheat_valid_o, cheat_clear_o;
	cheat_code_u            cheat_code_o;
	logic                   cart_loaded_o, flash_1m_o, sram_quirk_o, memory_remap_quirk_o;
	logic [1:0]             cart_type_o;
	logic [PAK_ADDR_W-1:0]  max_pak_addr_o;

	logic [15:0]            lfsr_q;            // Random source
	logic [BIOS_ADDR_W-1:0] exp_baddr_q [$];   // Model results waiting for a strobe
	logic [31:0]            exp_bdata_q [$];
	cheat_code_u            exp_cheat_q [$];
	int                     errors, tests, clear_cnt, cycles, cycle_limit;

	gba_loader_top dut_i (.*);

	always #5 clk_sys = ~clk_sys;

	// Run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the run did not end within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ========================================
	// Random bits and checks
	// ========================================
	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	task automatic report_error(input string msg);
		$display("** Error @ %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_bios(input logic [BIOS_ADDR_W-1:0] exp_addr, input logic [31:0] exp_data);
		if (bios_wraddr_o !== exp_addr || bios_wrdata_o !== exp_data)
			report_error($sformatf("BIOS word %h:%h, expected %h:%h",
				bios_wraddr_o, bios_wrdata_o, exp_addr, exp_data));
	endtask

	task automatic check_cheat(input cheat_code_u exp);
		if (cheat_code_o !== exp)
			report_error($sformatf("cheat record %h %h %h %h, expected %h %h %h %h",
				cheat_code_o.field.flags, cheat_code_o.field.address,
				cheat_code_o.field.compare, cheat_code_o.field.replace,
				exp.field.flags, exp.field.address, exp.field.compare, exp.field.replace));
	endtask

	task automatic check_cart(input logic [1:0] exp_type, input logic [PAK_ADDR_W-1:0] exp_pak,
			input logic exp_flash);
		if (cart_loaded_o !== 1'b1 || cart_type_o !== exp_type || max_pak_addr_o !== exp_pak
				|| flash_1m_o !== exp_flash)
			report_error($sformatf("cart loaded %b type %0d pak %h flash %b, expected 1 %0d %h %b",
				cart_loaded_o, cart_type_o, max_pak_addr_o, flash_1m_o,
				exp_type, exp_pak, exp_flash));
	endtask

	task automatic check_quirk(input logic exp_sram, input logic exp_remap);
		if (sram_quirk_o !== exp_sram || memory_remap_quirk_o !== exp_remap)
			report_error($sformatf("quirks sram %b remap %b, expected %b %b",
				sram_quirk_o, memory_remap_quirk_o, exp_sram, exp_remap));
	endtask

	// Strobe monitor, outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (!reset) begin
			if (bios_wr_o && exp_baddr_q.size() == 0)
				report_error("bios_wr_o pulse with no word pending");
			else if (bios_wr_o)
				check_bios(exp_baddr_q.pop_front(), exp_bdata_q.pop_front());
			if (cheat_valid_o && exp_cheat_q.size() == 0)
				report_error("cheat_valid_o pulse with no record pending");
			else if (cheat_valid_o)
				check_cheat(exp_cheat_q.pop_front());
			if (cheat_clear_o)
				clear_cnt++;
		end
	end

	// ========================================
	// Host stream driver
	// ========================================
	task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		int gap;
		gap = int'(take_bits(2));   // 0 to 3 idle cycles
		repeat (gap) @(negedge clk_sys);
		ioctl_wr_i   = 1'b1;
		ioctl_addr_i = addr;
		ioctl_dout_i = data;
		@(negedge clk_sys);
		ioctl_wr_i = 1'b0;
	endtask

	task automatic start_download(input logic [7:0] idx);
		ioctl_index_i = idx;   // Index settles while the download is low
		@(negedge clk_sys);
		ioctl_download_i = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		ioctl_download_i = 1'b0;
		repeat (3) @(negedge clk_sys);   // Results land two cycles after the fall
	endtask

	task automatic finish_test(input string name);
		while (exp_baddr_q.size() != 0 || exp_cheat_q.size() != 0)
			@(negedge clk_sys);
		tests++;
		$display("Test %0d %s done, %0d errors so far", tests, name, errors);
	endtask

	// ========================================
	// Tests
	// ========================================
	task automatic run_bios_test();
		logic [31:0]       r;
		logic [31:0]       word;
		logic [ADDR_W-1:0] addr;
		r = take_bits(8);
		start_download(IDX_BIOS);
		for (int w = 0; w < 8; w++) begin
			addr = ADDR_W'({r[7:0], 2'b00}) + ADDR_W'(4 * w);
			word = take_bits(32);
			exp_baddr_q.push_back(addr[13:2]);
			exp_bdata_q.push_back(word);   // Low halfword sits at the lower address
			host_write(addr, word[15:0]);
			host_write(addr + ADDR_W'(2), word[31:16]);
		end
		end_download();
		finish_test("BIOS download");
	endtask

	task automatic run_code_test();
		logic [31:0]       r;
		logic [DATA_W-1:0] half [8];
		cheat_code_u       exp;
		int                clear_before;
		clear_before = clear_cnt;
		start_download(IDX_CODE);
		for (int k = 0; k < 3; k++) begin
			for (int j = 0; j < 8; j++) begin
				r = take_bits(16);
				half[j] = r[15:0];
			end
			// Each field sends its bottom halfword first
			exp.field.flags   = {half[1], half[0]};
			exp.field.address = {half[3], half[2]};
			exp.field.compare = {half[5], half[4]};
			exp.field.replace = {half[7], half[6]};
			exp_cheat_q.push_back(exp);
			for (int j = 0; j < 8; j++)
				host_write(ADDR_W'(16 * k + 2 * j), half[j]);
		end
		end_download();
		if (clear_cnt != clear_before + 1)
			report_error($sformatf("%0d cheat_clear_o pulses, expected 1", clear_cnt - clear_before));
		finish_test("code download");
	endtask

	task automatic run_cart_test(input int num);
		logic [7:0]             img [256];
		logic [7:0]             idx;
		logic [31:0]            r;
		logic [TITLE_LEN*8-1:0] title;
		logic [ADDR_W-1:0]      last;
		logic                   exp_flash, exp_sram, exp_remap, match;
		int                     len, tbase;
		r     = take_bits(12);
		idx   = r[7:0];
		idx   = (idx == IDX_BIOS) ? 8'd1 : (idx == IDX_CODE) ? 8'd254 : idx;
		len   = 176 + 4 * int'(r[11:8]);   // Always past the title end
		tbase = int'(TITLE_BASE);
		for (int i = 0; i < len; i++) begin
			r = take_bits(8);
			img[i] = r[7:0];
		end
		r = take_bits(10);
		if (r[6])   // Marker at an even or odd offset ahead of the header title
			for (int i = 0; i < FLASH_MARK_LEN; i++)
				img[16 + int'(r[5:0]) + i] = FLASH_MARK[(FLASH_MARK_LEN - 1 - i) * 8 +: 8];
		// Cart 0 takes an SRAM-only entry, cart 3 a remap entry
		title = (num % 3 == 0) ? QUIRK_TITLES[{num[1], r[8:7]}] : "NOT IN TABLE";
		if (num % 3 != 2)   // Third kind keeps random title bytes
			for (int i = 0; i < TITLE_LEN; i++)
				img[tbase + i] = title[(TITLE_LEN - 1 - i) * 8 +: 8];

		// Model: marker search over the byte stream, then table lookup
		exp_flash = 1'b0;
		for (int p = 0; p + FLASH_MARK_LEN <= len; p++) begin
			match = 1'b1;
			for (int i = 0; i < FLASH_MARK_LEN; i++)
				if (img[p + i] != FLASH_MARK[(FLASH_MARK_LEN - 1 - i) * 8 +: 8])
					match = 1'b0;
			exp_flash = exp_flash | match;
		end
		for (int i = 0; i < TITLE_LEN; i++)
			title = {title[TITLE_LEN*8-9:0], img[tbase + i]};
		exp_sram  = 1'b0;
		exp_remap = 1'b0;
		for (int q = 0; q < QUIRK_N; q++) begin
			if (title == QUIRK_TITLES[q]) begin
				exp_sram  = 1'b1;
				exp_remap = exp_remap | QUIRK_REMAP[q];
			end
		end

		start_download(idx);
		for (int a = 0; a < len; a += 2)
			host_write(ADDR_W'(a), {img[a + 1], img[a]});   // Low byte first
		end_download();
		last = ADDR_W'(len - 2);
		check_cart(idx[7:6], last[ADDR_W-1:2], exp_flash);
		check_quirk(exp_sram, exp_remap);
		finish_test($sformatf("cart download %0d", num));
	endtask

	initial begin
		clk_sys          = 1'b0;
		reset            = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_index_i    = 8'd0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = '0;
		lfsr_q           = 16'd4;
		errors           = 0;
		tests            = 0;
		clear_cnt        = 0;
		// Reset, writes of up to 4 cycles each, 5 cycles around each of 9 downloads
		cycle_limit = 2 * (8 + 4 * (16 + 2 * 24 + 6 * 118) + 9 * 5) + 100;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
		run_bios_test();
		run_code_test();
		for (int c = 0; c < 6; c++)
			run_cart_test(c);
		run_code_test();
		$display("Summary: %0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
